// ==== rtl/mips_defs.svh ====
// core widths, memory depths and the nop instruction word
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data and instruction word width
`define MIPS_XLEN 32

// register number width, 32 registers
`define MIPS_REG_AW 5

// instruction memory word address, 256 words
`define MIPS_IMEM_AW 8

// data memory word address, 256 words
`define MIPS_DMEM_AW 8

// sll r0, r0, 0 encodes as all zeros
`define MIPS_NOP 32'h0000_0000

`endif

// ==== rtl/mips_pkg.sv ====
// package with word, register index, opcode, funct and alu operation types
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

	// instr[31:26], only the kept opcodes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// instr[5:0] of r-type
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_SRA = 6'h03,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_XOR = 4'b0011,
		ALU_SLL = 4'b0100,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111,
		ALU_SRL = 4'b1000,
		ALU_SRA = 4'b1001,
		ALU_LUI = 4'b1010,
		ALU_NOR = 4'b1100
	} alu_op_e;

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// program counter, loadable instruction memory and if/id register
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module fetch_stage (
	input wire clk,
	input wire rst,
	input wire run,
	input wire imem_we,
	input wire [`MIPS_IMEM_AW-1:0] imem_addr,
	input wire mips_pkg::word_t imem_data,
	input wire stall,
	output mips_pkg::word_t id_instr
);

	logic [`MIPS_IMEM_AW-1:0] pc; // word address
	mips_pkg::word_t imem [2**`MIPS_IMEM_AW];
	mips_pkg::word_t if_word;

	// loader port used while run is low
	always_ff @(posedge clk)
	begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	assign if_word = imem[pc]; // async read

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
			id_instr <= `MIPS_NOP;
		end
		else if (!stall) // load-use hold keeps both
		begin
			if (run)
			begin
				pc <= pc + 1'b1;
				id_instr <= if_word;
			end
			else
				id_instr <= `MIPS_NOP; // idle feeds bubbles
		end
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// 32 x 32 register file with two read ports, one write port and write-through
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module reg_file (
	input wire clk,
	input wire rst,
	input wire mips_pkg::reg_idx_t rs,
	input wire mips_pkg::reg_idx_t rt,
	input wire wb_en,
	input wire mips_pkg::reg_idx_t wb_reg,
	input wire mips_pkg::word_t wb_data,
	output mips_pkg::word_t rs_data,
	output mips_pkg::word_t rt_data
);

	mips_pkg::word_t regs [2**`MIPS_REG_AW];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 2**`MIPS_REG_AW; i++)
				regs[i] <= '0;
		end
		else if (wb_en)
			regs[wb_reg] <= wb_data;
	end

	// r0 is hardwired and a same-cycle write bypasses the array
	assign rs_data = (rs == '0) ? '0 :
		(wb_en && wb_reg == rs) ? wb_data : regs[rs];
	assign rt_data = (rt == '0) ? '0 :
		(wb_en && wb_reg == rt) ? wb_data : regs[rt];

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// instruction decode, immediate extension, load-use stall and id/ex register
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module decode_stage (
	input wire clk,
	input wire rst,
	input wire mips_pkg::word_t id_instr,
	input wire wb_en,
	input wire mips_pkg::reg_idx_t wb_reg,
	input wire mips_pkg::word_t wb_data,
	output logic stall,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write,
	output logic ex_alu_src,
	output mips_pkg::alu_op_e ex_alu_op,
	output mips_pkg::reg_idx_t ex_dest,
	output mips_pkg::reg_idx_t ex_rs,
	output mips_pkg::reg_idx_t ex_rt,
	output mips_pkg::word_t ex_rs_data,
	output mips_pkg::word_t ex_rt_data,
	output mips_pkg::word_t ex_imm,
	output logic [4:0] ex_shamt
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e funct;
	mips_pkg::reg_idx_t rs;
	mips_pkg::reg_idx_t rt;
	mips_pkg::reg_idx_t rd;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;
	mips_pkg::word_t imm;
	mips_pkg::alu_op_e alu_op;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic alu_src;
	logic use_rd; // r-type writes rd
	logic zero_ext; // logical immediates

	assign opcode = mips_pkg::opcode_e'(id_instr[31:26]);
	assign funct = mips_pkg::funct_e'(id_instr[5:0]);
	assign rs = id_instr[25:21];
	assign rt = id_instr[20:16];
	assign rd = id_instr[15:11];

	reg_file rf_i (
		.clk(clk),
		.rst(rst),
		.rs(rs),
		.rt(rt),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	always_comb
	begin
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		alu_src = 1'b1;
		use_rd = 1'b0;
		zero_ext = 1'b0;
		alu_op = mips_pkg::ALU_ADD;
		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				alu_src = 1'b0;
				use_rd = 1'b1;
				reg_write = 1'b1;
				case (funct)
					mips_pkg::FN_SLL: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA: alu_op = mips_pkg::ALU_SRA;
					mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					default: reg_write = 1'b0; // unknown funct acts as nop
				endcase
			end
			mips_pkg::OP_ADDI: reg_write = 1'b1;
			mips_pkg::OP_SLTI:
			begin
				reg_write = 1'b1;
				alu_op = mips_pkg::ALU_SLT;
			end
			mips_pkg::OP_ANDI:
			begin
				reg_write = 1'b1;
				zero_ext = 1'b1;
				alu_op = mips_pkg::ALU_AND;
			end
			mips_pkg::OP_ORI:
			begin
				reg_write = 1'b1;
				zero_ext = 1'b1;
				alu_op = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_XORI:
			begin
				reg_write = 1'b1;
				zero_ext = 1'b1;
				alu_op = mips_pkg::ALU_XOR;
			end
			mips_pkg::OP_LUI:
			begin
				reg_write = 1'b1;
				alu_op = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW:
			begin
				reg_write = 1'b1;
				mem_read = 1'b1; // address is rs + imm
			end
			mips_pkg::OP_SW: mem_write = 1'b1;
			default: alu_src = 1'b1; // unknown opcode writes nothing
		endcase
	end

	assign imm = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, id_instr[15:0]} :
		{{(`MIPS_XLEN-16){id_instr[15]}}, id_instr[15:0]};

	// load in id/ex feeding the instruction in if/id
	assign stall = ex_mem_read && ex_dest != '0 && (ex_dest == rs || ex_dest == rt);

	always_ff @(posedge clk)
	begin
		if (rst || stall) // stall inserts a bubble
		begin
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end
		else
		begin
			ex_reg_write <= reg_write;
			ex_mem_read <= mem_read;
			ex_mem_write <= mem_write;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_alu_src <= alu_src;
		ex_alu_op <= alu_op;
		ex_dest <= use_rd ? rd : rt;
		ex_rs <= rs;
		ex_rt <= rt;
		ex_rs_data <= rs_data;
		ex_rt_data <= rt_data;
		ex_imm <= imm;
		ex_shamt <= id_instr[10:6];
	end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// operand forwarding, alu and ex/mem register
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input wire clk,
	input wire rst,
	input wire ex_reg_write,
	input wire ex_mem_read,
	input wire ex_mem_write,
	input wire ex_alu_src,
	input wire mips_pkg::alu_op_e ex_alu_op,
	input wire mips_pkg::reg_idx_t ex_dest,
	input wire mips_pkg::reg_idx_t ex_rs,
	input wire mips_pkg::reg_idx_t ex_rt,
	input wire mips_pkg::word_t ex_rs_data,
	input wire mips_pkg::word_t ex_rt_data,
	input wire mips_pkg::word_t ex_imm,
	input wire [4:0] ex_shamt,
	input wire wb_en,
	input wire mips_pkg::reg_idx_t wb_reg,
	input wire mips_pkg::word_t wb_data,
	output logic mem_reg_write,
	output logic mem_mem_read,
	output logic mem_mem_write,
	output mips_pkg::reg_idx_t mem_dest,
	output mips_pkg::word_t mem_alu_result,
	output mips_pkg::word_t mem_store_data
);

	mips_pkg::word_t op_a; // forwarded rs
	mips_pkg::word_t fwd_rt; // forwarded rt
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_result;
	logic fwd_mem_ok;

	// ex/mem only counts when it writes a real register
	assign fwd_mem_ok = mem_reg_write && mem_dest != '0;

	always_comb
	begin
		if (fwd_mem_ok && mem_dest == ex_rs)
			op_a = mem_alu_result; // newest value wins
		else if (wb_en && wb_reg == ex_rs)
			op_a = wb_data;
		else
			op_a = ex_rs_data;
	end

	always_comb
	begin
		if (fwd_mem_ok && mem_dest == ex_rt)
			fwd_rt = mem_alu_result;
		else if (wb_en && wb_reg == ex_rt)
			fwd_rt = wb_data;
		else
			fwd_rt = ex_rt_data;
	end

	assign op_b = ex_alu_src ? ex_imm : fwd_rt;

	always_comb
	begin
		case (ex_alu_op)
			mips_pkg::ALU_ADD: alu_result = op_a + op_b; // wraps without an overflow trap
			mips_pkg::ALU_SUB: alu_result = op_a - op_b;
			mips_pkg::ALU_AND: alu_result = op_a & op_b;
			mips_pkg::ALU_OR: alu_result = op_a | op_b;
			mips_pkg::ALU_XOR: alu_result = op_a ^ op_b;
			mips_pkg::ALU_NOR: alu_result = ~(op_a | op_b);
			mips_pkg::ALU_SLT: alu_result = mips_pkg::word_t'($signed(op_a) < $signed(op_b));
			mips_pkg::ALU_SLL: alu_result = fwd_rt << ex_shamt;
			mips_pkg::ALU_SRL: alu_result = fwd_rt >> ex_shamt;
			mips_pkg::ALU_SRA: alu_result = $signed(fwd_rt) >>> ex_shamt;
			mips_pkg::ALU_LUI: alu_result = ex_imm << 16;
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_reg_write <= 1'b0;
			mem_mem_read <= 1'b0;
			mem_mem_write <= 1'b0;
		end
		else
		begin
			mem_reg_write <= ex_reg_write;
			mem_mem_read <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
		end
	end

	always_ff @(posedge clk)
	begin
		mem_dest <= ex_dest;
		mem_alu_result <= alu_result;
		mem_store_data <= fwd_rt; // sw data after forwarding
	end

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
// word-addressed data memory and mem/wb register driving the writeback bus
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module memory_stage (
	input wire clk,
	input wire rst,
	input wire mem_reg_write,
	input wire mem_mem_read,
	input wire mem_mem_write,
	input wire mips_pkg::reg_idx_t mem_dest,
	input wire mips_pkg::word_t mem_alu_result,
	input wire mips_pkg::word_t mem_store_data,
	output logic wb_en,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t wb_data
);

	mips_pkg::word_t dmem [2**`MIPS_DMEM_AW];
	logic [`MIPS_DMEM_AW-1:0] addr;
	mips_pkg::word_t rdata;

	assign addr = mem_alu_result[`MIPS_DMEM_AW-1:0]; // word index with upper bits ignored
	assign rdata = dmem[addr];

	always_ff @(posedge clk)
	begin
		if (mem_mem_write)
			dmem[addr] <= mem_store_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			wb_en <= 1'b0;
		else
			wb_en <= mem_reg_write && mem_dest != '0; // r0 writes never retire
	end

	always_ff @(posedge clk)
	begin
		wb_reg <= mem_dest;
		wb_data <= mem_mem_read ? rdata : mem_alu_result;
	end

endmodule

`default_nettype wire

// ==== rtl/mips_pipeline.sv ====
// top level wiring the fetch, decode, execute and memory stages
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module mips_pipeline (
	input wire clk,
	input wire rst,
	input wire run,
	input wire imem_we,
	input wire [`MIPS_IMEM_AW-1:0] imem_addr,
	input wire mips_pkg::word_t imem_data,
	output logic wb_en,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t wb_data
);

	mips_pkg::word_t id_instr;
	logic stall;

	// id/ex
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_alu_src;
	mips_pkg::alu_op_e ex_alu_op;
	mips_pkg::reg_idx_t ex_dest;
	mips_pkg::reg_idx_t ex_rs;
	mips_pkg::reg_idx_t ex_rt;
	mips_pkg::word_t ex_rs_data;
	mips_pkg::word_t ex_rt_data;
	mips_pkg::word_t ex_imm;
	logic [4:0] ex_shamt;

	// ex/mem
	logic mem_reg_write;
	logic mem_mem_read;
	logic mem_mem_write;
	mips_pkg::reg_idx_t mem_dest;
	mips_pkg::word_t mem_alu_result;
	mips_pkg::word_t mem_store_data;

	fetch_stage fetch_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.stall(stall),
		.id_instr(id_instr)
	);

	decode_stage decode_i (
		.clk(clk),
		.rst(rst),
		.id_instr(id_instr),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.stall(stall),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_alu_src(ex_alu_src),
		.ex_alu_op(ex_alu_op),
		.ex_dest(ex_dest),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_rs_data(ex_rs_data),
		.ex_rt_data(ex_rt_data),
		.ex_imm(ex_imm),
		.ex_shamt(ex_shamt)
	);

	execute_stage execute_i (
		.clk(clk),
		.rst(rst),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_alu_src(ex_alu_src),
		.ex_alu_op(ex_alu_op),
		.ex_dest(ex_dest),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_rs_data(ex_rs_data),
		.ex_rt_data(ex_rt_data),
		.ex_imm(ex_imm),
		.ex_shamt(ex_shamt),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.mem_reg_write(mem_reg_write),
		.mem_mem_read(mem_mem_read),
		.mem_mem_write(mem_mem_write),
		.mem_dest(mem_dest),
		.mem_alu_result(mem_alu_result),
		.mem_store_data(mem_store_data)
	);

	memory_stage memory_i (
		.clk(clk),
		.rst(rst),
		.mem_reg_write(mem_reg_write),
		.mem_mem_read(mem_mem_read),
		.mem_mem_write(mem_mem_write),
		.mem_dest(mem_dest),
		.mem_alu_result(mem_alu_result),
		.mem_store_data(mem_store_data),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== testbench/mips_tb.sv ====
// random program generator, reference isa model, writeback checker and timeout
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module mips_tb;

	localparam int PROG_LEN = 64;
	localparam int IMEM_DEPTH = 2**`MIPS_IMEM_AW;
	localparam int DMEM_DEPTH = 2**`MIPS_DMEM_AW;
	localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 100;

	// mips32 opcode and funct encodings
	localparam logic [5:0] OPC_RTYPE = 6'h00;
	localparam logic [5:0] OPC_ADDI = 6'h08;
	localparam logic [5:0] OPC_SLTI = 6'h0a;
	localparam logic [5:0] OPC_ANDI = 6'h0c;
	localparam logic [5:0] OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_XORI = 6'h0e;
	localparam logic [5:0] OPC_LUI = 6'h0f;
	localparam logic [5:0] OPC_LW = 6'h23;
	localparam logic [5:0] OPC_SW = 6'h2b;
	localparam logic [5:0] FUNCT_SLL = 6'h00;
	localparam logic [5:0] FUNCT_SRL = 6'h02;
	localparam logic [5:0] FUNCT_SRA = 6'h03;
	localparam logic [5:0] FUNCT_ADD = 6'h20;
	localparam logic [5:0] FUNCT_SUB = 6'h22;
	localparam logic [5:0] FUNCT_AND = 6'h24;
	localparam logic [5:0] FUNCT_OR = 6'h25;
	localparam logic [5:0] FUNCT_XOR = 6'h26;
	localparam logic [5:0] FUNCT_NOR = 6'h27;
	localparam logic [5:0] FUNCT_SLT = 6'h2a;

	localparam logic [5:0] R_FUNCTS [10] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_ADD,
		FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR, FUNCT_SLT};
	localparam logic [5:0] I_OPS [6] = '{OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI,
		OPC_LUI};
	localparam logic [5:0] BAD_OPS [4] = '{6'h02, 6'h04, 6'h20, 6'h3f}; // j, beq, lb, spare
	localparam logic [5:0] BAD_FUNCTS [2] = '{6'h01, 6'h08}; // spare, jr

	logic clk = 1'b0;
	logic rst;
	logic run;
	logic imem_we;
	logic [`MIPS_IMEM_AW-1:0] imem_addr;
	mips_pkg::word_t imem_data;
	logic wb_en;
	mips_pkg::reg_idx_t wb_reg;
	mips_pkg::word_t wb_data;

	mips_pkg::word_t prog [PROG_LEN];
	mips_pkg::word_t model_regs [32];
	mips_pkg::word_t model_dmem [DMEM_DEPTH];
	logic [4:0] exp_reg [$]; // expected writebacks in program order
	mips_pkg::word_t exp_val [$];
	int wb_seen;
	int run_cycles;

	mips_pipeline dut_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got,
				expected);
			$display("TESTS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [4:0] random_reg();
		return 5'($urandom % 8); // r0..r7 only for dense hazards
	endfunction

	function automatic mips_pkg::word_t encode_rtype(input logic [5:0] funct,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [4:0] shamt);
		return {OPC_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mips_pkg::word_t encode_itype(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program();
		int kind;
		logic [7:0] stored; // data words already written by sw
		logic [2:0] addr;
		stored = '0;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			kind = int'($urandom % 20);
			if (kind >= 13 && kind <= 15 && stored == '0)
				kind = 16; // no lw before the first sw
			if (kind < 7)
				prog[i] = encode_rtype(R_FUNCTS[$urandom % 10], random_reg(), random_reg(),
					random_reg(), 5'($urandom % 32));
			else if (kind < 13)
				prog[i] = encode_itype(I_OPS[$urandom % 6], random_reg(), random_reg(),
					16'($urandom));
			else if (kind < 16)
			begin
				addr = 3'($urandom % 8);
				while (!stored[addr])
					addr = addr + 1'b1;
				prog[i] = encode_itype(OPC_LW, 5'd0, random_reg(), {13'd0, addr});
			end
			else if (kind < 18)
			begin
				addr = 3'($urandom % 8);
				stored[addr] = 1'b1;
				prog[i] = encode_itype(OPC_SW, 5'd0, random_reg(), {13'd0, addr});
			end
			else if (kind == 18)
			begin
				if ($urandom % 2 == 0)
					prog[i] = encode_itype(BAD_OPS[$urandom % 4], random_reg(), random_reg(),
						16'($urandom));
				else
					prog[i] = encode_rtype(BAD_FUNCTS[$urandom % 2], random_reg(),
						random_reg(), random_reg(), 5'($urandom % 32));
			end
			else
				prog[i] = encode_itype(OPC_ADDI, random_reg(), 5'd0, 16'($urandom)); // to r0
		end
	endtask

	// in-order isa execution filling the expected writeback queues
	task automatic run_model();
		logic [5:0] op;
		logic [5:0] funct;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [4:0] dest;
		logic writes;
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t imm_s;
		mips_pkg::word_t imm_z;
		mips_pkg::word_t ea;
		mips_pkg::word_t res;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			op = prog[i][31:26];
			rs = prog[i][25:21];
			rt = prog[i][20:16];
			rd = prog[i][15:11];
			shamt = prog[i][10:6];
			funct = prog[i][5:0];
			a = model_regs[rs];
			b = model_regs[rt];
			imm_s = {{16{prog[i][15]}}, prog[i][15:0]};
			imm_z = {16'h0000, prog[i][15:0]};
			ea = a + imm_s;
			writes = 1'b1;
			dest = rt;
			res = '0;
			case (op)
				OPC_RTYPE:
				begin
					dest = rd;
					case (funct)
						FUNCT_SLL: res = b << shamt;
						FUNCT_SRL: res = b >> shamt;
						FUNCT_SRA: res = $signed(b) >>> shamt;
						FUNCT_ADD: res = a + b;
						FUNCT_SUB: res = a - b;
						FUNCT_AND: res = a & b;
						FUNCT_OR: res = a | b;
						FUNCT_XOR: res = a ^ b;
						FUNCT_NOR: res = ~(a | b);
						FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				OPC_ADDI: res = a + imm_s;
				OPC_SLTI: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
				OPC_ANDI: res = a & imm_z; // logical immediates zero-extend
				OPC_ORI: res = a | imm_z;
				OPC_XORI: res = a ^ imm_z;
				OPC_LUI: res = {prog[i][15:0], 16'h0000};
				OPC_LW: res = model_dmem[ea[`MIPS_DMEM_AW-1:0]];
				OPC_SW:
				begin
					model_dmem[ea[`MIPS_DMEM_AW-1:0]] = b;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != 5'd0)
			begin
				model_regs[dest] = res;
				exp_reg.push_back(dest);
				exp_val.push_back(res);
			end
		end
	endtask

	// whole imem with nops past the program
	task automatic load_program();
		for (int addr = 0; addr < IMEM_DEPTH; addr++)
		begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= `MIPS_IMEM_AW'(addr);
			imem_data <= (addr < PROG_LEN) ? prog[addr] : `MIPS_NOP;
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	// writeback monitor sampled mid-cycle
	always @(negedge clk)
	begin
		if (rst || !run)
			check_value("wb_en", {31'd0, wb_en}, 32'd0);
		else if (wb_en)
		begin
			if (wb_seen >= exp_reg.size())
			begin
				$display("extra writeback to r%0d at %0t ns after all expected writebacks",
					wb_reg, $time);
				$display("TESTS FAILED");
				$fatal(1, "extra writeback");
			end
			else
			begin
				check_value("wb_reg", {27'd0, wb_reg}, {27'd0, exp_reg[wb_seen]});
				check_value("wb_data", wb_data, exp_val[wb_seen]);
				wb_seen++;
			end
		end
	end

	always @(posedge clk)
	begin
		if (run)
		begin
			run_cycles++;
			if (run_cycles > TIMEOUT_CYCLES)
			begin
				$display("timeout: only %0d of %0d writebacks after %0d cycles", wb_seen,
					exp_reg.size(), TIMEOUT_CYCLES);
				$display("TESTS FAILED");
				$fatal(1, "timeout");
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		wb_seen = 0;
		run_cycles = 0;
		void'($urandom(32'hfeaf));
		build_program();
		run_model();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		load_program();
		@(posedge clk);
		run <= 1'b1;
		while (wb_seen < exp_reg.size())
			@(posedge clk);
		repeat (20) @(posedge clk); // quiet tail with no extra pulses
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_pipeline.sv
testbench/mips_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vmips_tb
SRCS := list.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS)
	verilator --binary --timing -Wno-fatal -f list.f --top-module mips_tb -o Vmips_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
